//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_tetris
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_STRING ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STRING)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// occupancy grid, row 0 at the top
bit model_board [FIELD_ROWS][FIELD_COLS];
logic [7:0] model_score;

function automatic bit occupied(input int r, input int c);
	if (r < 0 || r >= FIELD_ROWS || c < 0 || c >= FIELD_COLS) return 1'b0;
	return model_board[r][c];
endfunction

function automatic shape_e model_rotate(input shape_e s);
	case (s)
		sq: return sq;
		bar_h: return bar_v;
		bar_v: return bar_h;
		tee_3: return tee_0;
		ell_3: return ell_0;
		zed_0: return zed_1;
		zed_1: return zed_0;
		ess_0: return ess_1;
		ess_1: return ess_0;
		default: return shape_e'(s + 4'd1); // tee and ell step forward
	endcase
endfunction

task automatic model_reset();
	foreach (model_board[r, c]) model_board[r][c] = 1'b0;
	model_score = '0;
endtask

function automatic bit row_full(input int r);
	for (int c = 0; c < FIELD_COLS; c++) begin
		if (!model_board[r][c]) return 1'b0;
	end
	return 1'b1;
endfunction

// everything above row r moves down by one
task automatic drop_row(input int r);
	for (int y = r; y > 0; y--) begin
		for (int c = 0; c < FIELD_COLS; c++) model_board[y][c] = model_board[y-1][c];
	end
	for (int c = 0; c < FIELD_COLS; c++) model_board[0][c] = 1'b0;
endtask

task automatic model_apply(input req_t q, output res_t e);
	offset_t off;
	int cc [4];
	int rr [4];
	bit in_field [4];
	int n_clear;
	e = '0;
	n_clear = 0;
	e.shape = (q.op == op_rotate) ? model_rotate(q.shape) : q.shape;
	for (int i = 0; i < 4; i++) begin
		off = FOOTPRINT[q.shape][i];
		cc[i] = int'(q.col) + int'($signed(off.dc));
		rr[i] = int'(q.row) + int'(off.dr);
		in_field[i] = cc[i] >= 0 && cc[i] < FIELD_COLS && rr[i] < FIELD_ROWS;
	end
	if (q.op == op_probe || q.op == op_place) begin
		for (int i = 0; i < 4; i++) begin
			if (!in_field[i]) begin
				e.overlap = 1'b1;
			end else begin
				if (occupied(rr[i], cc[i])) e.overlap = 1'b1;
				if (rr[i] == FIELD_ROWS - 1 || occupied(rr[i] + 1, cc[i])) e.landed = 1'b1;
				if (cc[i] == 0 || occupied(rr[i], cc[i] - 1)) e.hit_left = 1'b1;
				if (cc[i] == FIELD_COLS - 1 || occupied(rr[i], cc[i] + 1)) e.hit_right = 1'b1;
			end
		end
	end
	if (q.op == op_place && e.landed && !e.overlap) begin
		for (int i = 0; i < 4; i++) model_board[rr[i]][cc[i]] = 1'b1;
		for (int r = FIELD_ROWS - 1; r >= 0; r--) begin
			while (row_full(r)) begin
				drop_row(r);
				n_clear++;
			end
		end
	end
	if (q.op == op_restart) model_reset();
	model_score = model_score + 8'(n_clear);
	e.cleared = 3'(n_clear);
	e.score = model_score;
endtask

`endif

//--- bench/tb_tetris.sv
`timescale 1ns/1ns

module tb_tetris import tetris_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int N_RAND = 200;
	localparam int N_SWEEP = 144;
	localparam int N_DIRECTED = 40; // upper bound over tests 1 to 4
	localparam int CYC_PER_REQ = 24; // res_ready is low about half the time
	localparam int TIMEOUT_NS =
		((N_DIRECTED + N_RAND + N_SWEEP) * CYC_PER_REQ + 10) * CLK_PERIOD;

	logic ADDR;
	logic rst_n;
	req_t req;
	logic req_valid;
	logic req_ready;
	res_t res;
	logic res_valid;
	logic res_ready;

	res_t exp_q [$];
	res_t expected;
	res_t head;
	res_t last_res;
	req_t rand_reqs [N_RAND];
	logic [31:0] lfsr = 32'h4f09_b818;
	logic lfsr_mode;
	int errors;
	int test_base;
	int n_tests;
	int n_reqs;
	int n_results;

	`include "tb_model.svh"

	tetris_engine uut (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.res(res),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	function automatic req_t make_req(input op_e op, input shape_e s, input int c, input int r);
		req_t m;
		m.op = op;
		m.shape = s;
		m.col = col_t'(c);
		m.row = row_t'(r);
		return m;
	endfunction

	// called 10 ns after an edge, returns 10 ns after the accepting edge
	task automatic send_req(input req_t r);
		req = r;
		req_valid = 1'b1;
		@(posedge ADDR);
		while (!req_ready) @(posedge ADDR);
		#10;
		req_valid = 1'b0;
	endtask

	task automatic finish_test(input string name);
		while (exp_q.size() > 0) begin
			@(posedge ADDR);
			#10;
		end
		n_tests++;
		if (errors == test_base) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		ADDR = 1'b0;
		forever #(CLK_PERIOD / 2) ADDR = ~ADDR;
	end

	initial begin
		res_ready = 1'b1;
		forever begin
			@(posedge ADDR);
			#10;
			res_ready = lfsr_mode ? 1'(take_bits(1)) : 1'b1;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns with %0d results still outstanding",
			TIMEOUT_NS, exp_q.size());
		$display("SIMULATION FAILED");
		$finish;
	end

	// expected values are queued on acceptance, results popped on transfer
	always @(posedge ADDR) begin
		if (rst_n && res_valid && res_ready) begin
			n_results++;
			last_res = res;
			assert (exp_q.size() > 0) else begin
				$display("result %h arrived at %0t ns with no request outstanding", res, $time);
				errors++;
			end
			if (exp_q.size() > 0) begin
				head = exp_q.pop_front();
				assert (res === head) else begin
					$display("FAILED %0t ns: res %h, expected %h", $time, res, head);
					errors++;
				end
			end
		end
		if (rst_n && req_valid && req_ready) begin
			model_apply(req, expected);
			exp_q.push_back(expected);
			n_reqs++;
		end
	end

	initial begin
		logic [2:0] kind;
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		lfsr_mode = 1'b0;
		errors = 0;
		test_base = 0;
		n_tests = 0;
		n_reqs = 0;
		n_results = 0;
		model_reset();
		repeat (3) @(posedge ADDR);
		#10;
		rst_n = 1'b1;

		for (int s = 0; s < 15; s++) send_req(make_req(op_rotate, shape_e'(s), 10, 5));
		finish_test("rotate");

		send_req(make_req(op_probe, bar_v, 0, 5)); // left edge
		send_req(make_req(op_probe, bar_h, 20, 5)); // right edge
		send_req(make_req(op_probe, sq, 10, 22)); // floor
		send_req(make_req(op_probe, bar_h, 22, 0)); // off the right side
		send_req(make_req(op_probe, tee_0, 0, 3));
		finish_test("edges");

		send_req(make_req(op_place, sq, 5, 22));
		send_req(make_req(op_probe, sq, 5, 20));
		send_req(make_req(op_probe, bar_v, 6, 19));
		send_req(make_req(op_place, sq, 12, 10)); // still in the air
		send_req(make_req(op_probe, sq, 12, 10));
		finish_test("lock");

		send_req(make_req(op_restart, sq, 0, 0));
		for (int c = 0; c < 20; c += 4) send_req(make_req(op_place, bar_h, c, 23));
		send_req(make_req(op_place, sq, 0, 21)); // rests on the bars
		send_req(make_req(op_place, bar_h, 20, 23));
		send_req(make_req(op_probe, sq, 0, 22));
		send_req(make_req(op_probe, sq, 0, 20));
		finish_test("row_clear");
		assert (last_res.score == 8'd1) else begin
			$display("FAILED %0t ns: score %0d after one full row", $time, last_res.score);
			errors++;
		end

		for (int i = 0; i < N_RAND; i++) begin
			kind = 3'(take_bits(3));
			rand_reqs[i].op = (kind < 3) ? op_probe : (kind < 6) ? op_place :
				(kind == 6) ? op_rotate : op_restart;
			rand_reqs[i].shape = shape_e'(4'(take_bits(4) % 15));
			rand_reqs[i].col = col_t'(take_bits(5) % 24);
			rand_reqs[i].row = row_t'(16 + take_bits(3)); // bias toward the floor
		end
		lfsr_mode = 1'b1;
		for (int i = 0; i < N_RAND; i++) send_req(rand_reqs[i]);
		finish_test("random");
		lfsr_mode = 1'b0;

		send_req(make_req(op_restart, bar_h, 3, 3));
		for (int r = 0; r < FIELD_ROWS; r += 2) begin
			for (int c = 0; c < FIELD_COLS; c += 2) send_req(make_req(op_probe, sq, c, r));
		end
		finish_test("restart");

		$display("%0d tests, %0d requests, %0d results, %0d errors",
			n_tests, n_reqs, n_results, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- logic/board_commit.sv
`timescale 1ns/1ns

module board_commit import tetris_pkg::*; (
	input logic ADDR,
	input logic rst_n,

	input chk_t chk,
	input logic chk_valid,
	output logic chk_ready,

	output logic [CELL_COUNT-1:0] board,
	output logic board_busy,

	output res_t res,
	output logic res_valid,
	input logic res_ready
);

	logic [CELL_COUNT-1:0] locked;
	logic [CELL_COUNT-1:0] board_next;
	logic [FIELD_COLS-1:0] row_bits;
	logic [7:0] score;
	logic [7:0] score_next;
	logic [2:0] cleared;
	op_e res_op;
	logic load;
	int dst;
	int n_full;

	assign chk_ready = !res_valid || res_ready;
	assign load = chk_valid && chk_ready;
	assign board_busy = res_valid && (res_op == op_place || res_op == op_restart);

	always_comb begin
		locked = board;
		if (chk.fp.op == op_place && chk.landed && !chk.overlap) begin
			for (int i = 0; i < 4; i++) begin
				locked[cell_index(chk.fp.cells[i].col, chk.fp.cells[i].row)] = 1'b1;
			end
		end

		// compact from the bottom, full rows drop out
		board_next = '0;
		dst = FIELD_ROWS - 1;
		n_full = 0;
		row_bits = '0;
		for (int r = FIELD_ROWS - 1; r >= 0; r--) begin
			row_bits = locked[r*FIELD_COLS +: FIELD_COLS];
			if (&row_bits) begin
				n_full++;
			end else begin
				board_next[dst*FIELD_COLS +: FIELD_COLS] = row_bits;
				dst--;
			end
		end

		cleared = 3'(n_full); // at most four per piece
		score_next = score + {5'b00000, cleared};

		if (chk.fp.op == op_restart) begin
			board_next = '0;
			cleared = '0;
			score_next = '0;
		end
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			board <= '0;
			score <= '0;
		end else if (load) begin
			res_valid <= 1'b1;
			board <= board_next;
			score <= score_next;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge ADDR) begin
		if (load) begin
			res_op <= chk.fp.op;
			res <= '{chk.fp.shape, chk.landed, chk.hit_left, chk.hit_right,
				chk.overlap, cleared, score_next};
		end
	end

endmodule

//--- logic/collision_check.sv
`timescale 1ns/1ns

module collision_check import tetris_pkg::*; (
	input logic ADDR,
	input logic rst_n,

	input fp_t fp,
	input logic fp_valid,
	output logic fp_ready,

	input logic [CELL_COUNT-1:0] board,
	input logic board_busy,

	output chk_t chk,
	output logic chk_valid,
	input logic chk_ready
);

	fp_t item;
	logic item_valid;
	cell_t cur;
	idx_t idx;
	logic landed;
	logic hit_left;
	logic hit_right;
	logic overlap;

	// flags follow the live board while the item waits
	always_comb begin
		landed = 1'b0;
		hit_left = 1'b0;
		hit_right = 1'b0;
		overlap = 1'b0;
		cur = '0;
		idx = '0;
		if (item.op == op_probe || item.op == op_place) begin
			for (int i = 0; i < 4; i++) begin
				cur = item.cells[i];
				idx = cell_index(cur.col, cur.row);
				if (!cur.in_field) begin
					overlap = 1'b1;
				end else begin
					if (board[idx]) overlap = 1'b1;

					if (cur.row == row_t'(FIELD_ROWS - 1)) landed = 1'b1; // floor
					else if (board[idx + idx_t'(FIELD_COLS)]) landed = 1'b1;

					if (cur.col == '0) hit_left = 1'b1;
					else if (board[idx - 1'b1]) hit_left = 1'b1;

					if (cur.col == col_t'(FIELD_COLS - 1)) hit_right = 1'b1;
					else if (board[idx + 1'b1]) hit_right = 1'b1;
				end
			end
		end
	end

	assign fp_ready = !item_valid || (chk_ready && !board_busy);
	assign chk_valid = item_valid && !board_busy; // wait for pending board update
	assign chk = '{item, landed, hit_left, hit_right, overlap};

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			item_valid <= 1'b0;
		end else if (fp_valid && fp_ready) begin
			item_valid <= 1'b1;
		end else if (chk_valid && chk_ready) begin
			item_valid <= 1'b0;
		end
	end

	always_ff @(posedge ADDR) begin
		if (fp_valid && fp_ready) begin
			item <= fp;
		end
	end

endmodule

//--- logic/piece_footprint.sv
`timescale 1ns/1ns

module piece_footprint import tetris_pkg::*; (
	input logic ADDR,
	input logic rst_n,

	input req_t req,
	input logic req_valid,
	output logic req_ready,

	output fp_t fp,
	output logic fp_valid,
	input logic fp_ready
);

	fp_t fp_next;
	offset_t off;
	logic signed [6:0] abs_col;
	logic [5:0] abs_row;
	logic load;

	assign req_ready = !fp_valid || fp_ready;
	assign load = req_valid && req_ready;

	always_comb begin
		fp_next.op = req.op;
		if (req.op == op_rotate) begin
			fp_next.shape = ROTATE_NEXT[req.shape];
		end else begin
			fp_next.shape = req.shape;
		end

		for (int i = 0; i < 4; i++) begin
			off = FOOTPRINT[req.shape][i];
			// anchor plus sign extended column offset
			abs_col = $signed({2'b00, req.col}) + $signed({{4{off.dc[2]}}, off.dc});
			abs_row = {1'b0, req.row} + {4'b0000, off.dr};

			fp_next.cells[i].col = abs_col[4:0];
			fp_next.cells[i].row = abs_row[4:0];
			fp_next.cells[i].in_field = !abs_col[6] &&
				(abs_col < FIELD_COLS) &&
				(abs_row < FIELD_ROWS);
		end
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			fp_valid <= 1'b0;
		end else if (load) begin
			fp_valid <= 1'b1;
		end else if (fp_ready) begin
			fp_valid <= 1'b0;
		end
	end

	always_ff @(posedge ADDR) begin
		if (load) begin
			fp <= fp_next;
		end
	end

endmodule

//--- logic/tetris_engine.sv
`timescale 1ns/1ns

module tetris_engine import tetris_pkg::*; (
	input logic ADDR,
	input logic rst_n,

	input req_t req,
	input logic req_valid,
	output logic req_ready,

	output res_t res,
	output logic res_valid,
	input logic res_ready
);

	fp_t fp;
	logic fp_valid;
	logic fp_ready;
	chk_t chk;
	logic chk_valid;
	logic chk_ready;
	logic [CELL_COUNT-1:0] board;
	logic board_busy;

	piece_footprint u_footprint (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.fp(fp),
		.fp_valid(fp_valid),
		.fp_ready(fp_ready)
	);

	// board feeds back from the last stage
	collision_check u_check (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.fp(fp),
		.fp_valid(fp_valid),
		.fp_ready(fp_ready),
		.board(board),
		.board_busy(board_busy),
		.chk(chk),
		.chk_valid(chk_valid),
		.chk_ready(chk_ready)
	);

	board_commit u_commit (
		.ADDR(ADDR),
		.rst_n(rst_n),
		.chk(chk),
		.chk_valid(chk_valid),
		.chk_ready(chk_ready),
		.board(board),
		.board_busy(board_busy),
		.res(res),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

endmodule

//--- logic/tetris_pkg.sv
package tetris_pkg;

	localparam int FIELD_COLS = 24;
	localparam int FIELD_ROWS = 24;
	localparam int CELL_COUNT = FIELD_COLS * FIELD_ROWS;
	localparam int IDX_W = $clog2(CELL_COUNT);

	typedef logic [4:0] col_t;
	typedef logic [4:0] row_t;
	typedef logic [IDX_W-1:0] idx_t;

	typedef enum logic [3:0] {
		sq, bar_h, bar_v,
		tee_0, tee_1, tee_2, tee_3,
		ell_0, ell_1, ell_2, ell_3,
		zed_0, zed_1,
		ess_0, ess_1
	} shape_e;

	typedef enum logic [1:0] {
		op_probe,
		op_place,
		op_rotate,
		op_restart
	} op_e;

	// one cell of a piece relative to its anchor
	typedef struct packed {
		logic signed [2:0] dc;
		logic [1:0] dr;
	} offset_t;

	localparam offset_t FOOTPRINT [15][4] = '{
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{ 3'sd0, 2'd1}, '{ 3'sd1, 2'd1}}, // sq
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{ 3'sd2, 2'd0}, '{ 3'sd3, 2'd0}}, // bar_h
		'{'{ 3'sd0, 2'd0}, '{ 3'sd0, 2'd1}, '{ 3'sd0, 2'd2}, '{ 3'sd0, 2'd3}}, // bar_v
		'{'{ 3'sd0, 2'd0}, '{-3'sd1, 2'd1}, '{ 3'sd0, 2'd1}, '{ 3'sd1, 2'd1}}, // tee_0
		'{'{ 3'sd0, 2'd0}, '{ 3'sd0, 2'd1}, '{ 3'sd1, 2'd1}, '{ 3'sd0, 2'd2}}, // tee_1
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{ 3'sd2, 2'd0}, '{ 3'sd1, 2'd1}}, // tee_2
		'{'{ 3'sd0, 2'd0}, '{-3'sd1, 2'd1}, '{ 3'sd0, 2'd1}, '{ 3'sd0, 2'd2}}, // tee_3
		'{'{ 3'sd0, 2'd0}, '{ 3'sd0, 2'd1}, '{ 3'sd0, 2'd2}, '{ 3'sd1, 2'd2}}, // ell_0
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{ 3'sd2, 2'd0}, '{ 3'sd0, 2'd1}}, // ell_1
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{ 3'sd1, 2'd1}, '{ 3'sd1, 2'd2}}, // ell_2
		'{'{ 3'sd0, 2'd0}, '{-3'sd2, 2'd1}, '{-3'sd1, 2'd1}, '{ 3'sd0, 2'd1}}, // ell_3
		'{'{ 3'sd0, 2'd0}, '{ 3'sd0, 2'd1}, '{ 3'sd1, 2'd1}, '{ 3'sd1, 2'd2}}, // zed_0
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{-3'sd1, 2'd1}, '{ 3'sd0, 2'd1}}, // zed_1
		'{'{ 3'sd0, 2'd0}, '{-3'sd1, 2'd1}, '{ 3'sd0, 2'd1}, '{-3'sd1, 2'd2}}, // ess_0
		'{'{ 3'sd0, 2'd0}, '{ 3'sd1, 2'd0}, '{ 3'sd1, 2'd1}, '{ 3'sd2, 2'd1}}  // ess_1
	};

	localparam shape_e ROTATE_NEXT [15] = '{
		sq, bar_v, bar_h,
		tee_1, tee_2, tee_3, tee_0,
		ell_1, ell_2, ell_3, ell_0,
		zed_1, zed_0,
		ess_1, ess_0
	};

	typedef struct packed {
		col_t col;
		row_t row;
		logic in_field;
	} cell_t;

	typedef struct packed {
		op_e op;
		shape_e shape;
		col_t col;
		row_t row;
	} req_t;

	typedef struct packed {
		op_e op;
		shape_e shape;
		cell_t [3:0] cells;
	} fp_t;

	typedef struct packed {
		fp_t fp;
		logic landed;
		logic hit_left;
		logic hit_right;
		logic overlap;
	} chk_t;

	typedef struct packed {
		shape_e shape;
		logic landed;
		logic hit_left;
		logic hit_right;
		logic overlap;
		logic [2:0] cleared;
		logic [7:0] score;
	} res_t;

	// row major, row 0 at the top
	function automatic idx_t cell_index(input col_t c, input row_t r);
		return idx_t'(r) * idx_t'(FIELD_COLS) + idx_t'(c);
	endfunction

endpackage

//--- verilog.f
+incdir+bench
logic/tetris_pkg.sv
logic/piece_footprint.sv
logic/collision_check.sv
logic/board_commit.sv
logic/tetris_engine.sv
bench/tb_tetris.sv
